/* verilog/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	// First fetch address after reset
	localparam logic [31:0] reset_vector = 32'h0000_0000;

	// Major opcodes, RV32I base
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_system = 7'b1110011;

	// System instructions matched on the whole word
	localparam logic [31:0] instr_ecall = 32'h0000_0073;
	localparam logic [31:0] instr_wfi = 32'h1050_0073;
	localparam logic [31:0] instr_mret = 32'h3020_0073;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_type_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_type_t;

	// Branch offset bits are scattered over the word
	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		logic [6:0] opcode;
	} b_type_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_type_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_type_t;

	typedef union packed {
		r_type_t r;
		i_type_t i;
		s_type_t s;
		b_type_t b;
		u_type_t u;
		j_type_t j;
	} rv_instr_u;

	typedef struct packed {
		logic is_jal;
		logic is_jalr;
		logic is_branch;
		logic is_mret;
		logic is_trap;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [31:0] b_imm;
		logic [31:0] j_imm;
	} predecode_t;

	// Record handed to decode, new entry marked by strobe toggle
	typedef struct packed {
		logic strobe;
		logic [31:0] pc;
		logic [31:0] instruction;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
	} fetch_data_t;

endpackage

`default_nettype wire

/* verilog/instr_predecode.sv */
`default_nettype none

module instr_predecode (
	input wire fetch_pkg::rv_instr_u i_instruction,
	output fetch_pkg::predecode_t o_predecode
);

	logic [6:0] opcode;
	logic is_r;
	logic is_i;
	logic is_s;
	logic is_b;
	logic is_jalr;
	logic have_rs1;
	logic have_rs2;
	logic have_rd;

	assign opcode = i_instruction.r.opcode;

	// Format classes
	assign is_r = opcode == fetch_pkg::op_reg;
	assign is_i = opcode == fetch_pkg::op_imm || opcode == fetch_pkg::op_load ||
		opcode == fetch_pkg::op_system;
	assign is_s = opcode == fetch_pkg::op_store;
	assign is_b = opcode == fetch_pkg::op_branch;
	assign is_jalr = opcode == fetch_pkg::op_jalr;

	// Which register fields the format really carries
	assign have_rs1 = is_i | is_r | is_s | is_b | is_jalr;
	assign have_rs2 = is_r | is_s | is_b;
	assign have_rd = !(is_s | is_b);

	always_comb begin
		o_predecode.is_jal = opcode == fetch_pkg::op_jal;
		o_predecode.is_jalr = is_jalr;
		o_predecode.is_branch = is_b;
		o_predecode.is_mret = i_instruction == fetch_pkg::instr_mret;
		// ECALL and WFI both park fetch until an interrupt
		o_predecode.is_trap = i_instruction == fetch_pkg::instr_ecall ||
			i_instruction == fetch_pkg::instr_wfi;

		o_predecode.rs1 = have_rs1 ? i_instruction.i.rs1 : 5'd0;
		o_predecode.rs2 = have_rs2 ? i_instruction.s.rs2 : 5'd0;
		o_predecode.rd = have_rd ? i_instruction.r.rd : 5'd0;

		o_predecode.b_imm = {{20{i_instruction.b.imm_12}}, i_instruction.b.imm_11,
			i_instruction.b.imm_10_5, i_instruction.b.imm_4_1, 1'b0};
		o_predecode.j_imm = {{12{i_instruction.j.imm_20}}, i_instruction.j.imm_19_12,
			i_instruction.j.imm_11, i_instruction.j.imm_10_1, 1'b0};
	end

endmodule

`default_nettype wire

/* verilog/branch_predictor.sv */
`default_nettype none

module branch_predictor (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic i_launch,
	input wire logic [31:0] i_launch_pc,
	input wire fetch_pkg::predecode_t i_predecode,
	input wire logic i_jump,
	input wire logic [31:0] i_jump_pc,
	output logic [31:0] o_pc_hint,
	output logic [31:0] o_bp_hit,
	output logic [31:0] o_bp_miss
);

	logic [31:0] launch_pc;
	logic [31:0] launch_offset;
	logic [31:0] offset;

	// Static rule: JAL taken, backward branch taken, rest falls through
	always_comb begin
		if (i_predecode.is_jal)
			offset = i_predecode.j_imm;
		else if (i_predecode.is_branch && i_predecode.b_imm[31])
			offset = i_predecode.b_imm;
		else
			offset = 32'd4;
	end

	always_ff @(posedge i_clock) begin
		if (i_launch) begin
			launch_pc <= i_launch_pc;
			launch_offset <= offset;
		end
	end

	assign o_pc_hint = launch_pc + launch_offset;

	// Score each resolved jump against the hint
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_bp_hit <= 32'd0;
			o_bp_miss <= 32'd0;
		end else if (i_jump) begin
			if (i_jump_pc == o_pc_hint)
				o_bp_hit <= o_bp_hit + 32'd1;
			else
				o_bp_miss <= o_bp_miss + 32'd1;
		end
	end

	// Execute resolves only after the sequencer has launched
	assert property (@(posedge i_clock) disable iff (i_reset) !(i_jump && i_launch));

endmodule

`default_nettype wire

/* verilog/instr_fetch_port.sv */
`default_nettype none

module instr_fetch_port (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic [31:0] i_address,
	output logic [31:0] o_word,
	output logic o_word_ready,
	output logic o_bus_request,
	output logic [31:0] o_bus_address,
	input wire logic i_bus_ready,
	input wire logic [31:0] i_bus_rdata
);

	logic [31:0] tag;
	logic valid;
	logic active;
	logic pending;
	logic [31:0] pending_address;

	assign o_word_ready = valid && tag == i_address;

	// A miss starts a request at once; an open one keeps its latched address
	assign o_bus_request = active && (pending || !o_word_ready);
	assign o_bus_address = pending ? pending_address : i_address;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			valid <= 1'b0;
			active <= 1'b0;
			pending <= 1'b0;
		end else begin
			active <= 1'b1;
			if (o_bus_request && i_bus_ready) begin
				pending <= 1'b0;
				valid <= 1'b1;
				o_word <= i_bus_rdata;
				tag <= o_bus_address;
			end else if (o_bus_request && !pending) begin
				pending <= 1'b1;
				pending_address <= i_address;
			end
		end
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus_address));

endmodule

`default_nettype wire

/* verilog/fetch_sequencer.sv */
`default_nettype none

module fetch_sequencer (
	input wire logic i_clock,
	input wire logic i_reset,

	// Fetch port and predecode
	input wire logic [31:0] i_word,
	input wire logic i_word_ready,
	input wire fetch_pkg::predecode_t i_predecode,
	output logic [31:0] o_pc,

	// Predictor
	output logic o_launch,
	input wire logic [31:0] i_pc_hint,

	// Execute redirect
	input wire logic i_jump,
	input wire logic [31:0] i_jump_pc,

	// Interrupt
	input wire logic i_irq_pending,
	input wire logic [31:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [31:0] o_irq_epc,

	// Decode side
	input wire logic i_busy,
	output fetch_pkg::fetch_data_t o_data
);

	typedef enum logic [1:0] {
		WAIT_ICACHE,
		WAIT_JUMP,
		WAIT_IRQ
	} state_t;

	state_t state;
	logic irq_prev;
	logic irq_edge;
	logic irq_take;
	logic is_flow;
	logic accept;

	assign irq_edge = !irq_prev && i_irq_pending;
	// Edges are dropped while waiting on execute
	assign irq_take = irq_edge && (state == WAIT_ICACHE || state == WAIT_IRQ);

	assign is_flow = i_predecode.is_jal | i_predecode.is_jalr |
		i_predecode.is_branch | i_predecode.is_mret;

	// Interrupt edge wins over a ready word
	assign accept = state == WAIT_ICACHE && i_word_ready && !i_busy && !irq_edge;
	assign o_launch = accept && is_flow;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= WAIT_ICACHE;
			o_pc <= fetch_pkg::reset_vector;
			irq_prev <= 1'b0;
			o_irq_dispatched <= 1'b0;
			o_data <= '0;
		end else begin
			irq_prev <= i_irq_pending;
			o_irq_dispatched <= 1'b0;

			if (irq_take) begin
				o_irq_dispatched <= 1'b1;
				o_irq_epc <= o_pc;
				o_pc <= i_irq_pc;
				state <= WAIT_ICACHE;
			end else begin
				case (state)
					WAIT_ICACHE: begin
						if (accept) begin
							o_data.strobe <= ~o_data.strobe;
							o_data.pc <= o_pc;
							o_data.instruction <= i_word;
							o_data.rs1 <= i_predecode.rs1;
							o_data.rs2 <= i_predecode.rs2;
							o_data.rd <= i_predecode.rd;

							if (is_flow)
								state <= WAIT_JUMP;
							else if (i_predecode.is_trap)
								state <= WAIT_IRQ;
							else
								o_pc <= o_pc + 32'd4;
						end
					end

					WAIT_JUMP: begin
						// Prefetch follows the hint until execute resolves
						if (i_jump) begin
							o_pc <= i_jump_pc;
							state <= WAIT_ICACHE;
						end else begin
							o_pc <= i_pc_hint;
						end
					end

					WAIT_IRQ: begin
						// Left only through irq_take
						state <= WAIT_IRQ;
					end

					default: begin
						state <= WAIT_ICACHE;
					end
				endcase
			end
		end
	end

	// Redirect sources all come from outside this block
	assert property (@(posedge i_clock) disable iff (i_reset) o_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* verilog/fetch_top.sv */
`default_nettype none

module fetch_top (
	input wire logic i_clock,
	input wire logic i_reset,

	input wire logic i_jump,
	input wire logic [31:0] i_jump_pc,

	input wire logic i_irq_pending,
	input wire logic [31:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [31:0] o_irq_epc,

	// Instruction bus
	output logic o_bus_request,
	output logic [31:0] o_bus_address,
	input wire logic i_bus_ready,
	input wire logic [31:0] i_bus_rdata,

	input wire logic i_busy,
	output fetch_pkg::fetch_data_t o_data,

	output logic [31:0] o_debug_pc,
	output logic [31:0] o_debug_bp_hit,
	output logic [31:0] o_debug_bp_miss
);

	logic [31:0] pc;
	logic [31:0] word;
	logic word_ready;
	logic launch;
	logic [31:0] pc_hint;
	fetch_pkg::predecode_t predecode;

	assign o_debug_pc = pc;

	instr_fetch_port u_port (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_address(pc),
		.o_word(word),
		.o_word_ready(word_ready),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	instr_predecode u_predecode (
		.i_instruction(word),
		.o_predecode(predecode)
	);

	branch_predictor u_predictor (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_launch(launch),
		.i_launch_pc(pc),
		.i_predecode(predecode),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.o_pc_hint(pc_hint),
		.o_bp_hit(o_debug_bp_hit),
		.o_bp_miss(o_debug_bp_miss)
	);

	fetch_sequencer u_sequencer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_word(word),
		.i_word_ready(word_ready),
		.i_predecode(predecode),
		.o_pc(pc),
		.o_launch(launch),
		.i_pc_hint(pc_hint),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.i_busy(i_busy),
		.o_data(o_data)
	);

endmodule

`default_nettype wire

/* sim/tb_fetch.sv */
`default_nettype none

module tb_fetch;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_rows = 18;
	localparam int watchdog_cycles = num_rows * 40;

	localparam logic [1:0] act_none = 2'd0;
	localparam logic [1:0] act_busy = 2'd1;
	localparam logic [1:0] act_jump = 2'd2;
	localparam logic [1:0] act_irq = 2'd3;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		logic [1:0] action;
		logic [31:0] arg;
		logic [31:0] offset;
	} row_t;

	logic i_clock;
	logic i_reset;
	logic i_jump;
	logic [31:0] i_jump_pc;
	logic i_irq_pending;
	logic [31:0] i_irq_pc;
	logic o_irq_dispatched;
	logic [31:0] o_irq_epc;
	logic o_bus_request;
	logic [31:0] o_bus_address;
	logic i_bus_ready;
	logic [31:0] i_bus_rdata;
	logic i_busy;
	fetch_pkg::fetch_data_t o_data;
	logic [31:0] o_debug_pc;
	logic [31:0] o_debug_bp_hit;
	logic [31:0] o_debug_bp_miss;

	row_t rows [num_rows];
	logic [31:0] mem [logic [31:0]];
	logic last_strobe;
	logic [31:0] hit_expected;
	logic [31:0] miss_expected;

	fetch_top u_dut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.i_busy(i_busy),
		.o_data(o_data),
		.o_debug_pc(o_debug_pc),
		.o_debug_bp_hit(o_debug_bp_hit),
		.o_debug_bp_miss(o_debug_bp_miss)
	);

	initial begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected)
		else stop_with_failure($sformatf("Fail at %0t ns: %s = %h, expected %h",
			$time, name, got, expected));
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// Unlisted addresses hold an ALU op built from every address bit
	function automatic logic [31:0] read_word(input logic [31:0] address);
		if (mem.exists(address))
			return mem[address];
		return {address[31:7] ^ address[24:0], fetch_pkg::op_imm};
	endfunction

	function automatic logic [31:0] enc_branch(input logic [2:0] funct3, input logic [4:0] rs1,
			input logic [4:0] rs2, input int offset);
		fetch_pkg::rv_instr_u word;
		word.b.imm_12 = offset[12];
		word.b.imm_10_5 = offset[10:5];
		word.b.rs2 = rs2;
		word.b.rs1 = rs1;
		word.b.funct3 = funct3;
		word.b.imm_4_1 = offset[4:1];
		word.b.imm_11 = offset[11];
		word.b.opcode = fetch_pkg::op_branch;
		return word;
	endfunction

	function automatic logic [31:0] enc_jal(input logic [4:0] rd, input int offset);
		fetch_pkg::rv_instr_u word;
		word.j.imm_20 = offset[20];
		word.j.imm_10_1 = offset[10:1];
		word.j.imm_11 = offset[11];
		word.j.imm_19_12 = offset[19:12];
		word.j.rd = rd;
		word.j.opcode = fetch_pkg::op_jal;
		return word;
	endfunction

	// Register fields kept per format and packed as {rs1, rs2, rd}
	function automatic logic [14:0] expected_indices(input logic [31:0] instr);
		logic [6:0] opcode;
		logic rs1_used;
		logic rs2_used;
		logic rd_used;
		opcode = instr[6:0];
		rs2_used = opcode == fetch_pkg::op_reg || opcode == fetch_pkg::op_store ||
			opcode == fetch_pkg::op_branch;
		rs1_used = rs2_used || opcode == fetch_pkg::op_imm || opcode == fetch_pkg::op_load ||
			opcode == fetch_pkg::op_system || opcode == fetch_pkg::op_jalr;
		rd_used = opcode != fetch_pkg::op_store && opcode != fetch_pkg::op_branch;
		return {rs1_used ? instr[19:15] : 5'd0, rs2_used ? instr[24:20] : 5'd0,
			rd_used ? instr[11:7] : 5'd0};
	endfunction

	// Backward taken, forward not taken, JAL always taken
	function automatic logic [31:0] static_hint(input row_t row);
		if (row.instr[6:0] == fetch_pkg::op_jal)
			return row.pc + row.offset;
		if (row.instr[6:0] == fetch_pkg::op_branch && row.offset[31])
			return row.pc + row.offset;
		return row.pc + 32'd4;
	endfunction

	task automatic set_row(input int index, input logic [31:0] pc, input logic [31:0] instr,
			input logic [1:0] action, input logic [31:0] arg, input int offset);
		rows[index].pc = pc;
		rows[index].instr = instr;
		rows[index].action = action;
		rows[index].arg = arg;
		rows[index].offset = offset;
		mem[pc] = instr;
	endtask

	task automatic wait_record();
		@(posedge i_clock);
		while (o_data.strobe == last_strobe)
			@(posedge i_clock);
		last_strobe = o_data.strobe;
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(posedge i_clock);
			assert (o_data.strobe == last_strobe)
			else stop_with_failure("A record was delivered while fetch should be stalled");
		end
	endtask

	task automatic check_record(input row_t row);
		logic [14:0] idx;
		idx = expected_indices(row.instr);
		check_value("o_data.pc", o_data.pc, row.pc);
		check_value("o_data.instruction", o_data.instruction, row.instr);
		check_value("o_data.rs1", 32'(o_data.rs1), 32'(idx[14:10]));
		check_value("o_data.rs2", 32'(o_data.rs2), 32'(idx[9:5]));
		check_value("o_data.rd", 32'(o_data.rd), 32'(idx[4:0]));
	endtask

	task automatic apply_busy(input int cycles);
		i_busy <= 1'b1;
		expect_quiet(cycles);
		i_busy <= 1'b0;
	endtask

	task automatic apply_jump(input row_t row);
		expect_quiet(3);
		// Prefetch sits on the static target while execute resolves
		check_value("o_debug_pc", o_debug_pc, static_hint(row));
		i_jump <= 1'b1;
		i_jump_pc <= row.arg;
		if (row.arg == static_hint(row))
			hit_expected = hit_expected + 32'd1;
		else
			miss_expected = miss_expected + 32'd1;
		@(posedge i_clock);
		i_jump <= 1'b0;
		@(posedge i_clock);
		check_value("o_debug_bp_hit", o_debug_bp_hit, hit_expected);
		check_value("o_debug_bp_miss", o_debug_bp_miss, miss_expected);
	endtask

	// Level stays high for several cycles with one dispatch per edge
	task automatic apply_irq(input row_t row);
		logic is_trap;
		logic [31:0] epc_expected;
		logic [31:0] dispatches;
		is_trap = row.instr == fetch_pkg::instr_ecall || row.instr == fetch_pkg::instr_wfi;
		epc_expected = is_trap ? row.pc : row.pc + 32'd4;
		dispatches = 32'd0;
		if (is_trap)
			expect_quiet(3);
		i_irq_pending <= 1'b1;
		i_irq_pc <= row.arg;
		repeat (5) begin
			@(posedge i_clock);
			if (o_irq_dispatched) begin
				dispatches = dispatches + 32'd1;
				check_value("o_irq_epc", o_irq_epc, epc_expected);
			end
		end
		i_irq_pending <= 1'b0;
		check_value("irq dispatch count", dispatches, 32'd1);
	endtask

	// Bus slave with 0 to 3 extra wait cycles per request
	initial begin : memory_model
		logic [31:0] lfsr;
		logic [1:0] delay;
		logic counting;
		lfsr = 32'h0c32_d8e0;
		delay = 2'd0;
		counting = 1'b0;
		i_bus_ready <= 1'b0;
		i_bus_rdata <= 32'd0;
		forever begin
			@(posedge i_clock);
			if (i_bus_ready) begin
				i_bus_ready <= 1'b0;
			end else if (o_bus_request) begin
				if (!counting) begin
					counting = 1'b1;
					lfsr = lfsr_next(lfsr);
					delay[0] = lfsr[0];
					lfsr = lfsr_next(lfsr);
					delay[1] = lfsr[0];
				end
				if (delay == 2'd0) begin
					i_bus_ready <= 1'b1;
					i_bus_rdata <= read_word(o_bus_address);
					counting = 1'b0;
				end else begin
					delay = delay - 2'd1;
				end
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge i_clock);
		stop_with_failure("Timeout: the fetch unit stopped delivering records");
	end

	initial begin
		i_reset <= 1'b1;
		i_jump <= 1'b0;
		i_jump_pc <= 32'd0;
		i_irq_pending <= 1'b0;
		i_irq_pc <= 32'd0;
		i_busy <= 1'b0;
		last_strobe = 1'b0;
		hit_expected = 32'd0;
		miss_expected = 32'd0;

		// Straight line code, back-pressure and an asynchronous interrupt
		set_row(0, 32'h000, 32'h123452b7, act_none, 32'd0, 0);
		set_row(1, 32'h004, 32'h01028313, act_busy, 32'd5, 0);
		set_row(2, 32'h008, 32'h006283b3, act_none, 32'd0, 0);
		set_row(3, 32'h00c, 32'h00712423, act_none, 32'd0, 0);
		set_row(4, 32'h010, 32'h00412403, act_irq, 32'h100, 0);
		set_row(5, 32'h100, 32'h00001497, act_none, 32'd0, 0);
		// Forward branch, JAL, then a short loop closed by a backward branch
		set_row(6, 32'h104, enc_branch(3'b000, 5'd1, 5'd2, 64), act_jump, 32'h144, 64);
		set_row(7, 32'h144, enc_jal(5'd1, 60), act_jump, 32'h180, 60);
		set_row(8, 32'h180, 32'h00100513, act_none, 32'd0, 0);
		set_row(9, 32'h184, enc_branch(3'b001, 5'd10, 5'd0, -4), act_jump, 32'h180, -4);
		set_row(10, 32'h180, 32'h00100513, act_none, 32'd0, 0);
		set_row(11, 32'h184, enc_branch(3'b001, 5'd10, 5'd0, -4), act_jump, 32'h188, -4);
		set_row(12, 32'h188, 32'h00008067, act_jump, 32'h200, 0);
		// Traps parked until an interrupt with an MRET in between
		set_row(13, 32'h200, fetch_pkg::instr_ecall, act_irq, 32'h300, 0);
		set_row(14, 32'h300, 32'h00d665b3, act_none, 32'd0, 0);
		set_row(15, 32'h304, fetch_pkg::instr_mret, act_jump, 32'h308, 0);
		set_row(16, 32'h308, fetch_pkg::instr_wfi, act_irq, 32'h400, 0);
		set_row(17, 32'h400, 32'h003200a3, act_none, 32'd0, 0);

		repeat (4) @(posedge i_clock);
		i_reset <= 1'b0;
		check_value("o_bus_request", 32'(o_bus_request), 32'd0);
		check_value("o_data.strobe", 32'(o_data.strobe), 32'd0);
		check_value("o_irq_dispatched", 32'(o_irq_dispatched), 32'd0);
		check_value("o_debug_bp_hit", o_debug_bp_hit, 32'd0);
		check_value("o_debug_bp_miss", o_debug_bp_miss, 32'd0);

		@(posedge i_clock);
		while (!o_bus_request)
			@(posedge i_clock);
		check_value("o_bus_address", o_bus_address, fetch_pkg::reset_vector);

		for (int i = 0; i < num_rows; i++) begin
			wait_record();
			check_record(rows[i]);
			case (rows[i].action)
				act_busy: apply_busy(int'(rows[i].arg));
				act_jump: apply_jump(rows[i]);
				act_irq: apply_irq(rows[i]);
				default: begin
				end
			endcase
		end

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
verilog/fetch_pkg.sv
verilog/instr_predecode.sv
verilog/branch_predictor.sv
verilog/instr_fetch_port.sv
verilog/fetch_sequencer.sv
verilog/fetch_top.sv
sim/tb_fetch.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_fetch
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= All tests passed
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
